// ==== verilog/rv_int_consts.svh ====
//--------------------------------------
// rv_int core constants
// widths, opcodes and funct codes
//--------------------------------------
`ifndef RV_INT_CONSTS_SVH
`define RV_INT_CONSTS_SVH

// widths
`define RV_XLEN             32
`define RV_REG_ADDR_BITS    5
`define RV_IMEM_ADDR_BITS   10

// major opcodes
`define RV_OPC_LUI          7'b0110111
`define RV_OPC_OP_IMM       7'b0010011
`define RV_OPC_OP           7'b0110011
`define RV_OPC_SYSTEM       7'b1110011

// funct3 for the integer ops
`define RV_F3_ADD           3'b000
`define RV_F3_XOR           3'b100
`define RV_F3_OR            3'b110
`define RV_F3_AND           3'b111

// funct7 for register-register ops
`define RV_F7_BASE          7'b0000000
`define RV_F7_SUB           7'b0100000

`define RV_EBREAK_WORD      32'h0010_0073

`endif

// ==== verilog/rv_int_pkg.sv ====
//--------------------------------------
// rv_int core types
//--------------------------------------
`default_nettype none

`include "rv_int_consts.svh"

package rv_int_pkg;

    // data and instruction words
    typedef logic [`RV_XLEN-1:0] word_t;

    // byte address of an instruction
    typedef logic [`RV_XLEN-1:0] pc_t;

    typedef logic [`RV_REG_ADDR_BITS-1:0] reg_addr_t;

    // word address into instruction memory
    typedef logic [`RV_IMEM_ADDR_BITS-1:0] imem_addr_t;

    // execute operation, halt covers ebreak and unknown encodings
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM,
        ALU_HALT
    } alu_op_e;

    typedef enum logic {
        CORE_PAUSED,
        CORE_RUN
    } core_state_e;

endpackage

`default_nettype wire

// ==== verilog/rv_int_fetch.sv ====
//--------------------------------------
// rv_int fetch stage
// pc sequencing and instruction reads
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rv_int_consts.svh"

module rv_int_fetch
    import rv_int_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              run_i,
    input  wire              launch_i,
    input  wire pc_t         start_address_i,
    input  wire word_t       imem_rdata_i,
    output logic             imem_re_o,
    output imem_addr_t       imem_addr_o,
    output logic             fetched_o,
    output word_t            fetched_word_o,
    output pc_t              fetched_pc_o
);

    pc_t  pc_q;
    logic read_pending_q;
    pc_t  read_pc_q;

    //--------------------------------------
    // pc sequencing
    //--------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (launch_i) begin
            pc_q <= start_address_i;
        end else if (run_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // one read per cycle while running
    assign imem_re_o   = run_i;
    assign imem_addr_o = pc_q[`RV_IMEM_ADDR_BITS+1:2];

    //--------------------------------------
    // pair returned word with its pc
    //--------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_pending_q <= 1'b0;
        end else begin
            read_pending_q <= imem_re_o;
        end
    end

    always_ff @(posedge clk) begin
        read_pc_q <= pc_q;
    end

    // memory answers one cycle after the read strobe
    assign fetched_o      = read_pending_q;
    assign fetched_word_o = imem_rdata_i;
    assign fetched_pc_o   = read_pc_q;

endmodule

`default_nettype wire

// ==== verilog/rv_int_decode.sv ====
//--------------------------------------
// rv_int decode stage
// classifies the word, holds the fields
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rv_int_consts.svh"

module rv_int_decode
    import rv_int_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              fetched_i,
    input  wire word_t       fetched_word_i,
    input  wire pc_t         fetched_pc_i,
    output logic             valid_o,
    output alu_op_e          op_o,
    output reg_addr_t        rd_o,
    output reg_addr_t        rs1_o,
    output reg_addr_t        rs2_o,
    output word_t            imm_o,
    output pc_t              pc_o,
    output word_t            ir_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_u_type;
    alu_op_e    op_d;
    word_t      imm_d;

    // funct3 to logic op, same table for both op classes
    function automatic alu_op_e op_from_funct3(input logic [2:0] f3);
        case (f3)
            `RV_F3_ADD: return ALU_ADD;
            `RV_F3_XOR: return ALU_XOR;
            `RV_F3_OR:  return ALU_OR;
            `RV_F3_AND: return ALU_AND;
            default:    return ALU_HALT;
        endcase
    endfunction

    assign opcode     = fetched_word_i[6:0];
    assign funct3     = fetched_word_i[14:12];
    assign funct7     = fetched_word_i[31:25];
    assign imm_i_type = {{20{fetched_word_i[31]}}, fetched_word_i[31:20]};
    assign imm_u_type = {fetched_word_i[31:12], 12'h000};

    //--------------------------------------
    // classify
    //--------------------------------------
    always_comb begin
        op_d  = ALU_HALT;
        imm_d = imm_i_type;
        case (opcode)
            `RV_OPC_LUI: begin
                op_d  = ALU_PASS_IMM;
                imm_d = imm_u_type;
            end
            `RV_OPC_OP_IMM: begin
                op_d = op_from_funct3(funct3);
            end
            `RV_OPC_OP: begin
                if (funct7 == `RV_F7_BASE) begin
                    op_d = op_from_funct3(funct3);
                end else if (funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD) begin
                    op_d = ALU_SUB;
                end
            end
            // ebreak, and any other system op
            `RV_OPC_SYSTEM: op_d = ALU_HALT;
            default:        op_d = ALU_HALT;
        endcase
    end

    //--------------------------------------
    // stage register
    //--------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= fetched_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetched_i) begin
            op_o  <= op_d;
            rd_o  <= fetched_word_i[11:7];
            rs1_o <= fetched_word_i[19:15];
            rs2_o <= fetched_word_i[24:20];
            imm_o <= imm_d;
            pc_o  <= fetched_pc_i;
            ir_o  <= fetched_word_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_int_execute.sv ====
//--------------------------------------
// rv_int execute stage
// run control, register file, alu
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rv_int_consts.svh"

module rv_int_execute
    import rv_int_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              start_i,
    input  wire              valid_i,
    input  wire alu_op_e     op_i,
    input  wire reg_addr_t   rd_i,
    input  wire reg_addr_t   rs1_i,
    input  wire reg_addr_t   rs2_i,
    input  wire word_t       imm_i,
    input  wire pc_t         pc_i,
    input  wire word_t       ir_i,
    input  wire reg_addr_t   ocd_reg_read_addr_i,
    input  wire              ocd_reg_we_i,
    input  wire reg_addr_t   ocd_reg_write_addr_i,
    input  wire word_t       ocd_reg_write_data_i,
    output logic             run_o,
    output logic             launch_o,
    output word_t            ocd_reg_read_data_o,
    output logic             retire_o,
    output pc_t              peek_pc_o,
    output word_t            peek_ir_o,
    output logic             processor_paused_o
);

    core_state_e state_q;
    logic        running;
    logic        halt;
    word_t       rf_q [32];
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       operand_b;
    word_t       result;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    word_t       rf_wdata;

    //--------------------------------------
    // run / pause control
    //--------------------------------------
    assign running            = (state_q == CORE_RUN);
    assign run_o              = running;
    assign launch_o           = start_i && !running;
    assign processor_paused_o = !running;

    // valid is dropped while paused, flushing words fetched after a halt
    assign retire_o  = valid_i && running;
    assign halt      = retire_o && (op_i == ALU_HALT);
    assign peek_pc_o = pc_i;
    assign peek_ir_o = ir_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CORE_PAUSED;
        end else begin
            case (state_q)
                CORE_PAUSED: if (launch_o) state_q <= CORE_RUN;
                CORE_RUN:    if (halt) state_q <= CORE_PAUSED;
                default:     state_q <= CORE_PAUSED;
            endcase
        end
    end

    //--------------------------------------
    // operands and alu
    //--------------------------------------
    assign rs1_data  = rf_q[rs1_i];
    assign rs2_data  = rf_q[rs2_i];
    assign operand_b = (ir_i[6:0] == `RV_OPC_OP_IMM) ? imm_i : rs2_data;

    always_comb begin
        case (op_i)
            ALU_ADD:      result = rs1_data + operand_b;
            ALU_SUB:      result = rs1_data - operand_b;
            ALU_AND:      result = rs1_data & operand_b;
            ALU_OR:       result = rs1_data | operand_b;
            ALU_XOR:      result = rs1_data ^ operand_b;
            ALU_PASS_IMM: result = imm_i;
            default:      result = '0;
        endcase
    end

    //--------------------------------------
    // register file
    //--------------------------------------
    // debugger owns the write port while paused
    always_comb begin
        if (running) begin
            rf_we    = retire_o && (op_i != ALU_HALT);
            rf_waddr = rd_i;
            rf_wdata = result;
        end else begin
            rf_we    = ocd_reg_we_i;
            rf_waddr = ocd_reg_write_addr_i;
            rf_wdata = ocd_reg_write_data_i;
        end
    end

    // x0 is never written so it stays zero
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != '0)) begin
            rf_q[rf_waddr] <= rf_wdata;
        end
    end

    assign ocd_reg_read_data_o = rf_q[ocd_reg_read_addr_i];

endmodule

`default_nettype wire

// ==== verilog/rv_int_core.sv ====
//--------------------------------------
// rv_int core top
// fetch, decode and execute in a row
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rv_int_core
    import rv_int_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              start_i,
    input  wire pc_t         start_address_i,
    output logic             imem_re_o,
    output imem_addr_t       imem_addr_o,
    input  wire word_t       imem_rdata_i,
    input  wire reg_addr_t   ocd_reg_read_addr_i,
    input  wire              ocd_reg_we_i,
    input  wire reg_addr_t   ocd_reg_write_addr_i,
    input  wire word_t       ocd_reg_write_data_i,
    output word_t            ocd_reg_read_data_o,
    output logic             retire_o,
    output pc_t              peek_pc_o,
    output word_t            peek_ir_o,
    output logic             processor_paused_o
);

    logic      run;
    logic      launch;
    logic      fetched;
    word_t     fetched_word;
    pc_t       fetched_pc;
    logic      dec_valid;
    alu_op_e   dec_op;
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    word_t     dec_imm;
    pc_t       dec_pc;
    word_t     dec_ir;

    //--------------------------------------
    // fetch
    //--------------------------------------
    rv_int_fetch u_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .run_i           (run),
        .launch_i        (launch),
        .start_address_i (start_address_i),
        .imem_rdata_i    (imem_rdata_i),
        .imem_re_o       (imem_re_o),
        .imem_addr_o     (imem_addr_o),
        .fetched_o       (fetched),
        .fetched_word_o  (fetched_word),
        .fetched_pc_o    (fetched_pc)
    );

    //--------------------------------------
    // decode
    //--------------------------------------
    rv_int_decode u_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetched_i      (fetched),
        .fetched_word_i (fetched_word),
        .fetched_pc_i   (fetched_pc),
        .valid_o        (dec_valid),
        .op_o           (dec_op),
        .rd_o           (dec_rd),
        .rs1_o          (dec_rs1),
        .rs2_o          (dec_rs2),
        .imm_o          (dec_imm),
        .pc_o           (dec_pc),
        .ir_o           (dec_ir)
    );

    //--------------------------------------
    // execute
    //--------------------------------------
    rv_int_execute u_execute (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .start_i              (start_i),
        .valid_i              (dec_valid),
        .op_i                 (dec_op),
        .rd_i                 (dec_rd),
        .rs1_i                (dec_rs1),
        .rs2_i                (dec_rs2),
        .imm_i                (dec_imm),
        .pc_i                 (dec_pc),
        .ir_i                 (dec_ir),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .run_o                (run),
        .launch_o             (launch),
        .ocd_reg_read_data_o  (ocd_reg_read_data_o),
        .retire_o             (retire_o),
        .peek_pc_o            (peek_pc_o),
        .peek_ir_o            (peek_ir_o),
        .processor_paused_o   (processor_paused_o)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_int_core_asserts.sv ====
//--------------------------------------
// rv_int core assertions
// pause, retire and fetch address rules
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rv_int_core_asserts
    import rv_int_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              retire_i,
    input  wire              imem_re_i,
    input  wire imem_addr_t  imem_addr_i,
    input  wire              paused_i
);

    // failed assertions, summed into the testbench result
    int unsigned fail_count = 0;

    // nothing retires while paused
    retire_when_paused: assert property (
        @(posedge clk) disable iff (!rst_n_i) paused_i |-> !retire_i
    ) else begin
        fail_count++;
        $error("retire_o high while processor_paused_o is high");
    end

    // no instruction reads while paused
    fetch_when_paused: assert property (
        @(posedge clk) disable iff (!rst_n_i) paused_i |-> !imem_re_i
    ) else begin
        fail_count++;
        $error("imem_re_o high while processor_paused_o is high");
    end

    // back-to-back reads walk forward one word
    sequential_fetch: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (imem_re_i && $past(imem_re_i)) |->
            (imem_addr_i == imem_addr_t'($past(imem_addr_i) + 1'b1))
    ) else begin
        fail_count++;
        $error("imem_addr_o did not advance by one between reads");
    end

endmodule

bind rv_int_core rv_int_core_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .retire_i    (retire_o),
    .imem_re_i   (imem_re_o),
    .imem_addr_i (imem_addr_o),
    .paused_i    (processor_paused_o)
);

`default_nettype wire

// ==== testbench/rv_int_core_tb.sv ====
//--------------------------------------
// rv_int core testbench
// random programs against a register model
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "rv_int_consts.svh"

module rv_int_core_tb
    import rv_int_pkg::*;
();

    localparam int    RESET_CYCLES   = 16;
    localparam int    PROG_LEN       = 40;
    localparam int    PROG_CYCLES    = 60;
    localparam int    REG_CYCLES     = 32;
    localparam int    NUM_TESTS      = 5;
    localparam int    TIMEOUT_CYCLES =
        RESET_CYCLES + NUM_TESTS * (PROG_CYCLES + 2 * REG_CYCLES) + 100;
    localparam word_t LFSR_SEED      = 32'hc6a0;
    localparam word_t LFSR_TAPS      = 32'h8020_0003;

    logic       clk;
    logic       rst_n_i;
    logic       start_i;
    pc_t        start_address_i;
    logic       imem_re_o;
    imem_addr_t imem_addr_o;
    word_t      imem_rdata_i;
    reg_addr_t  ocd_reg_read_addr_i;
    logic       ocd_reg_we_i;
    reg_addr_t  ocd_reg_write_addr_i;
    word_t      ocd_reg_write_data_i;
    word_t      ocd_reg_read_data_o;
    logic       retire_o;
    pc_t        peek_pc_o;
    word_t      peek_ir_o;
    logic       processor_paused_o;

    word_t      imem [1024];
    word_t      model_rf [32];
    word_t      lfsr_q;
    int         errors;
    int         test_errors;
    int         tests_run;
    int         tests_failed;
    int         cycle_count;
    int         base;
    int         exp_retires;

    rv_int_core dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // instruction memory answers one cycle after the read
    always @(posedge clk) begin
        if (imem_re_o) begin
            imem_rdata_i <= #2 imem[imem_addr_o];
        end
    end

    //--------------------------------------
    // random bits
    //--------------------------------------
    function automatic word_t lfsr_next(input word_t s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    //--------------------------------------
    // checks and reporting
    //--------------------------------------
    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("error: %s", msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    // debugger reads of every register against the model
    task automatic compare_regs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2;
            ocd_reg_read_addr_i = reg_addr_t'(i);
            @(negedge clk);
            check_word($sformatf("x%0d", i), ocd_reg_read_data_o, model_rf[i]);
        end
    endtask

    task automatic write_random_regs();
        word_t v;
        for (int i = 1; i <= 32; i++) begin
            v = take_bits(32);
            @(posedge clk);
            #2;
            ocd_reg_we_i         = 1'b1;
            ocd_reg_write_addr_i = reg_addr_t'(i);
            ocd_reg_write_data_i = v;
            // the last write goes to x0 and must be dropped
            if (i < 32) begin
                model_rf[i] = v;
            end
        end
        @(posedge clk);
        #2;
        ocd_reg_we_i = 1'b0;
    endtask

    //--------------------------------------
    // program generation and model
    //--------------------------------------
    task automatic gen_instr(input bit apply, output word_t w);
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        word_t       simm;
        word_t       a;
        word_t       b;
        word_t       r;
        kind  = int'(take_bits(4)) % 10;
        rd    = reg_addr_t'(take_bits(5));
        rs1   = reg_addr_t'(take_bits(5));
        rs2   = reg_addr_t'(take_bits(5));
        imm12 = 12'(take_bits(12));
        imm20 = 20'(take_bits(20));
        simm  = {{20{imm12[11]}}, imm12};
        a     = model_rf[rs1];
        b     = model_rf[rs2];
        case (kind)
            0: begin
                w = {imm20, rd, `RV_OPC_LUI};
                r = {imm20, 12'h000};
            end
            1: begin
                w = {imm12, rs1, `RV_F3_ADD, rd, `RV_OPC_OP_IMM};
                r = a + simm;
            end
            2: begin
                w = {imm12, rs1, `RV_F3_AND, rd, `RV_OPC_OP_IMM};
                r = a & simm;
            end
            3: begin
                w = {imm12, rs1, `RV_F3_OR, rd, `RV_OPC_OP_IMM};
                r = a | simm;
            end
            4: begin
                w = {imm12, rs1, `RV_F3_XOR, rd, `RV_OPC_OP_IMM};
                r = a ^ simm;
            end
            5: begin
                w = {`RV_F7_BASE, rs2, rs1, `RV_F3_ADD, rd, `RV_OPC_OP};
                r = a + b;
            end
            6: begin
                w = {`RV_F7_SUB, rs2, rs1, `RV_F3_ADD, rd, `RV_OPC_OP};
                r = a - b;
            end
            7: begin
                w = {`RV_F7_BASE, rs2, rs1, `RV_F3_AND, rd, `RV_OPC_OP};
                r = a & b;
            end
            8: begin
                w = {`RV_F7_BASE, rs2, rs1, `RV_F3_OR, rd, `RV_OPC_OP};
                r = a | b;
            end
            default: begin
                w = {`RV_F7_BASE, rs2, rs1, `RV_F3_XOR, rd, `RV_OPC_OP};
                r = a ^ b;
            end
        endcase
        // x0 as destination leaves it at zero
        if (apply && rd != '0) begin
            model_rf[rd] = r;
        end
    endtask

    // bad_at below zero means no unknown encoding in the program
    task automatic load_program(input int start, input int bad_at, output int retires);
        bit    halted;
        word_t w;
        word_t junk;
        halted  = 1'b0;
        retires = PROG_LEN + 1;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i == bad_at) begin
                // load opcode, outside the supported subset
                junk    = take_bits(25);
                w       = {junk[24:0], 7'b0000011};
                halted  = 1'b1;
                retires = i + 1;
            end else begin
                gen_instr(!halted, w);
            end
            imem[start + i] = w;
        end
        imem[start + PROG_LEN] = `RV_EBREAK_WORD;
    endtask

    //--------------------------------------
    // start a program and follow its retires
    //--------------------------------------
    task automatic run_program(input pc_t start_addr, input int retires_exp, input bit poke);
        int  retired;
        int  cycles;
        bit  done;
        pc_t exp_pc;
        retired = 0;
        cycles  = 0;
        done    = 1'b0;
        @(posedge clk);
        #2;
        start_address_i = start_addr;
        start_i         = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        while (!done && cycles < PROG_CYCLES) begin
            @(negedge clk);
            if (retire_o) begin
                exp_pc = start_addr + pc_t'(4 * retired);
                check_pc("peek_pc_o", peek_pc_o, exp_pc);
                check_word("peek_ir_o", peek_ir_o, imem[exp_pc[11:2]]);
                retired++;
            end else if (retired > 0 && !processor_paused_o) begin
                report_failure("retire gap before the core paused");
            end
            done = processor_paused_o;
            @(posedge clk);
            #2;
            // debugger writes while running must have no effect
            if (poke && retired < 20) begin
                ocd_reg_we_i         = 1'b1;
                ocd_reg_write_addr_i = reg_addr_t'(take_bits(5));
                ocd_reg_write_data_i = take_bits(32);
            end else begin
                ocd_reg_we_i = 1'b0;
            end
            cycles++;
        end
        ocd_reg_we_i = 1'b0;
        if (!done) begin
            report_failure("core did not pause within the run limit");
        end
        check_word("retire count", word_t'(retired), word_t'(retires_exp));
        // flush time before the next start
        repeat (4) begin
            @(negedge clk);
            check_bit("retire_o", retire_o, 1'b0);
            check_bit("imem_re_o", imem_re_o, 1'b0);
        end
    endtask

    //--------------------------------------
    // main sequence
    //--------------------------------------
    initial begin
        lfsr_q               = LFSR_SEED;
        errors               = 0;
        test_errors          = 0;
        tests_run            = 0;
        tests_failed         = 0;
        rst_n_i              = 1'b0;
        start_i              = 1'b0;
        start_address_i      = '0;
        imem_rdata_i         = '0;
        ocd_reg_read_addr_i  = '0;
        ocd_reg_we_i         = 1'b0;
        ocd_reg_write_addr_i = '0;
        ocd_reg_write_data_i = '0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = 32'hbad0_0000 | word_t'(i << 10) | word_t'(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        @(negedge clk);
        check_bit("processor_paused_o", processor_paused_o, 1'b1);
        check_bit("imem_re_o", imem_re_o, 1'b0);
        check_bit("retire_o", retire_o, 1'b0);
        compare_regs();
        finish_test("reset");

        write_random_regs();
        compare_regs();
        finish_test("debugger access");

        base = 32 + int'(take_bits(6));
        load_program(base, -1, exp_retires);
        run_program(pc_t'(base * 4), exp_retires, 1'b0);
        compare_regs();
        finish_test("program run");

        base = 400 + int'(take_bits(6));
        load_program(base, -1, exp_retires);
        run_program(pc_t'(base * 4), exp_retires, 1'b1);
        compare_regs();
        finish_test("restart");

        base = 800 + int'(take_bits(6));
        load_program(base, 12 + int'(take_bits(4)), exp_retires);
        run_program(pc_t'(base * 4), exp_retires, 1'b0);
        compare_regs();
        finish_test("unknown encoding");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut.u_asserts.fail_count);
        if (errors == 0 && dut.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_int_core.f ====
+incdir+verilog
verilog/rv_int_pkg.sv
verilog/rv_int_fetch.sv
verilog/rv_int_decode.sv
verilog/rv_int_execute.sv
verilog/rv_int_core.sv
testbench/rv_int_core_asserts.sv
testbench/rv_int_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_int_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_int_pkg.sv
      - verilog/rv_int_fetch.sv
      - verilog/rv_int_decode.sv
      - verilog/rv_int_execute.sv
      - verilog/rv_int_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/rv_int_core_asserts.sv
      - testbench/rv_int_core_tb.sv
